/* Makefile */
# Verilator simulation of the exception unit
# a failing run ends in $fatal, which gives a non-zero exit status

VERILATOR ?= verilator
TOP       ?= exc_unit_tb
SRC_F     ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps

EXE := $(BUILD_DIR)/V$(TOP)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(SRC_F) --Mdir $(BUILD_DIR)
	./$(EXE)

clean:
	rm -rf $(BUILD_DIR)

/* bench/exc_unit_tb.sv */
`timescale 1ns/1ps
`include "cp0_settings.svh"

module exc_unit_tb;

    import cp0_pkg::*;

    localparam word_t NOP = 32'h0000_0000;

    logic      clk;
    logic      reset;
    word_t     instr;
    word_t     pc;
    logic      in_delay_slot;
    exc_code_t exc_code;
    word_t     write_data;
    irq_t      irq;
    logic      exc_taken;
    word_t     epc_out;
    word_t     read_data;

    word_t     rng_state;
    string     test_name;
    int        take_count;
    int        irq_take_count;

    // reference model state
    word_t     m_status;
    word_t     m_cause;
    word_t     m_epc;
    irq_t      m_sync0;
    irq_t      m_sync1;     // model of the synchronized lines
    logic      m_irq_hit;
    logic      m_exc_hit;
    logic      m_take;
    exc_code_t m_code;
    word_t     m_read;

    exc_unit_top dut (
        .clk           (clk),
        .reset         (reset),
        .instr         (instr),
        .pc            (pc),
        .in_delay_slot (in_delay_slot),
        .exc_code      (exc_code),
        .write_data    (write_data),
        .irq           (irq),
        .exc_taken     (exc_taken),
        .epc_out       (epc_out),
        .read_data     (read_data)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic word_t xorshift(input word_t x);
        word_t y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // codes the pipeline may raise
    function automatic logic is_supported_code(input exc_code_t c);
        return (c == `EXC_ADEL) || (c == `EXC_ADES) || (c == `EXC_RI) || (c == `EXC_OV);
    endfunction

    function automatic word_t mtc0_word(input logic [4:0] r);
        return {`CP0_MTC0_PREFIX, 5'd8, r, 11'd0};
    endfunction

    function automatic word_t mfc0_word(input logic [4:0] r);
        return {`CP0_MFC0_PREFIX, 5'd2, r, 11'd0};
    endfunction

    function automatic word_t status_word(input irq_t im, input logic exl, input logic ie);
        return {16'h0000, im, 8'h00, exl, ie};
    endfunction

    function automatic irq_t irq_bit(input int b);
        irq_t v;
        v = '0;
        v[b] = 1'b1;
        return v;
    endfunction

    // decision and read path from the current inputs
    always_comb begin
        m_irq_hit = (|(m_sync1 & m_status[15:10])) && m_status[0] && !m_status[1];
        m_exc_hit = is_supported_code(exc_code) && !m_status[1];
        m_take    = m_irq_hit || m_exc_hit;
        m_code    = m_irq_hit ? `EXC_INT : exc_code;
    end

    always_comb begin
        case (instr[15:11])
            CP0_STATUS: m_read = m_status;
            CP0_CAUSE:  m_read = m_cause;
            CP0_EPC:    m_read = m_epc;
            CP0_PRID:   m_read = `CP0_PRID_VALUE;
            default:    m_read = 32'hffff_ffff;
        endcase
    end

    always @(posedge clk) begin
        if (reset) begin
            m_status <= '0;
            m_cause  <= '0;
            m_epc    <= '0;
            m_sync0  <= '0;
            m_sync1  <= '0;
        end else begin
            m_sync0 <= irq;
            m_sync1 <= m_sync0;
            if (m_take) begin
                m_epc        <= in_delay_slot ? pc - 32'd4 : pc;
                m_cause[31]  <= in_delay_slot;
                m_cause[6:2] <= m_code;
                m_status[1]  <= 1'b1;
            end else if (instr == `CP0_ERET_WORD) begin
                m_status[1] <= 1'b0;
            end else if (instr[31:21] == `CP0_MTC0_PREFIX) begin
                if (instr[15:11] == CP0_STATUS) m_status <= write_data;
                if (instr[15:11] == CP0_CAUSE) m_cause <= write_data;
                if (instr[15:11] == CP0_EPC) m_epc <= write_data;
            end
            m_cause[15:10] <= m_sync1;  // IP field wins over a cause write
        end
    end

    always @(negedge clk) begin
        if (!reset && exc_taken) begin
            take_count <= take_count + 1;
            if (m_irq_hit) irq_take_count <= irq_take_count + 1;
        end
    end

    task automatic report_mismatch(input string what, input word_t expected,
                                   input word_t actual);
        $display("Fail %s %s expected %h actual %h", test_name, what, expected, actual);
        $display("Test failed");
        $fatal(1, "output mismatch");
    endtask

    task automatic report_timeout(input string what);
        $display("Test failed");
        $fatal(1, "timed out in %s waiting for %s", test_name, what);
    endtask

    a_taken: assert property (@(posedge clk) disable iff (reset) exc_taken == m_take)
        else report_mismatch("exc_taken", 32'($sampled(m_take)), 32'($sampled(exc_taken)));

    a_read: assert property (@(posedge clk) disable iff (reset) read_data == m_read)
        else report_mismatch("read_data", $sampled(m_read), $sampled(read_data));

    a_epc: assert property (@(posedge clk) disable iff (reset)
        epc_out == {m_epc[31:2], 2'b00})
        else report_mismatch("epc_out", {$sampled(m_epc[31:2]), 2'b00}, $sampled(epc_out));

    // one cycle of the execute stage
    task automatic issue(input word_t i, input word_t p, input logic ds,
                         input exc_code_t c, input word_t wd);
        @(posedge clk);
        instr         <= i;
        pc            <= p;
        in_delay_slot <= ds;
        exc_code      <= c;
        write_data    <= wd;
    endtask

    task automatic idle(input int n);
        repeat (n) issue(NOP, 32'h0, 1'b0, `EXC_INT, 32'h0);
    endtask

    task automatic write_reg(input logic [4:0] r, input word_t d);
        issue(mtc0_word(r), 32'h0, 1'b0, `EXC_INT, d);
    endtask

    task automatic read_reg(input logic [4:0] r);
        issue(mfc0_word(r), 32'h0, 1'b0, `EXC_INT, 32'h0);
    endtask

    task automatic eret();
        issue(`CP0_ERET_WORD, 32'h0, 1'b0, `EXC_INT, 32'h0);
    endtask

    task automatic drive_irq(input irq_t v);
        @(posedge clk);
        irq           <= v;
        instr         <= NOP;
        in_delay_slot <= 1'b0;
        exc_code      <= `EXC_INT;
    endtask

    // sampled mid-cycle, limit 0 means the current cycle only
    task automatic wait_for_take(input int limit, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!exc_taken) begin
            if (n >= limit) begin
                report_timeout(what);
            end else begin
                n++;
                @(negedge clk);
            end
        end
    endtask

    initial begin
        #1_000_000;
        $display("Test failed");
        $fatal(1, "watchdog expired before the test finished");
    end

    initial begin
        word_t p;
        word_t d;
        int    k;
        int    j;
        rng_state      = 32'd98363;
        take_count     = 0;
        irq_take_count = 0;
        test_name      = "reset";
        reset         <= 1'b1;
        instr         <= NOP;
        pc            <= 32'h0;
        in_delay_slot <= 1'b0;
        exc_code      <= `EXC_INT;
        write_data    <= 32'h0;
        irq           <= '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        read_reg(CP0_STATUS);
        read_reg(CP0_CAUSE);
        read_reg(CP0_EPC);
        read_reg(CP0_PRID);
        read_reg(5'd3);     // not implemented

        test_name = "round_trip";
        for (int n = 0; n < 4; n++) begin
            d = next_rand();
            write_reg(CP0_STATUS, d);
            read_reg(CP0_STATUS);
            d = next_rand();
            write_reg(CP0_EPC, d);
            read_reg(CP0_EPC);
        end
        write_reg(CP0_STATUS, 32'h0);
        for (int n = 0; n < 4; n++) begin
            d = next_rand();
            drive_irq(d[5:0]);
            write_reg(CP0_CAUSE, next_rand());
            idle(2);
            read_reg(CP0_CAUSE);
        end
        write_reg(CP0_PRID, next_rand());
        read_reg(CP0_PRID);
        drive_irq('0);
        idle(3);

        test_name = "sync_exc";
        p = next_rand();
        issue(NOP, p, 1'b0, `EXC_OV, 32'h0);
        wait_for_take(0, "overflow exception");
        read_reg(CP0_EPC);
        read_reg(CP0_CAUSE);
        read_reg(CP0_STATUS);
        issue(NOP, next_rand(), 1'b0, `EXC_OV, 32'h0);  // blocked by EXL
        eret();
        for (int c = 0; c < 32; c++) begin
            if (!is_supported_code(exc_code_t'(c))) begin
                issue(NOP, next_rand(), 1'b0, exc_code_t'(c), 32'h0);
            end
        end

        test_name = "delay_slot";
        p = next_rand();
        issue(NOP, p, 1'b1, `EXC_RI, 32'h0);
        wait_for_take(0, "reserved instruction in delay slot");
        read_reg(CP0_EPC);
        read_reg(CP0_CAUSE);
        eret();

        test_name = "interrupt";
        k = int'(next_rand() % 32'd6);
        j = (k + 1) % 6;
        write_reg(CP0_STATUS, status_word(irq_bit(k), 1'b0, 1'b1));
        drive_irq(irq_bit(k));
        wait_for_take(8, "unmasked interrupt");
        read_reg(CP0_CAUSE);
        drive_irq('0);
        idle(4);
        eret();
        drive_irq(irq_bit(j));  // masked line
        idle(5);
        read_reg(CP0_CAUSE);
        drive_irq('0);
        idle(4);
        // interrupt held back by EXL, then released together with an exception
        write_reg(CP0_STATUS, status_word(irq_bit(k), 1'b1, 1'b1));
        drive_irq(irq_bit(k));
        idle(4);
        eret();
        issue(NOP, next_rand(), 1'b0, `EXC_OV, 32'h0);
        wait_for_take(0, "interrupt together with exception");
        read_reg(CP0_CAUSE);
        drive_irq('0);
        idle(4);

        test_name = "eret";
        eret();
        p = next_rand();
        issue(NOP, p, 1'b0, `EXC_OV, 32'h0);
        wait_for_take(0, "exception after eret");
        eret();
        p = next_rand();
        d = next_rand();
        issue(mtc0_word(CP0_EPC), p, 1'b0, `EXC_ADEL, d);
        wait_for_take(0, "exception during mtc0");
        read_reg(CP0_EPC);
        eret();
        idle(2);
        @(posedge clk);

        if (take_count == 6 && irq_take_count == 2) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "expected 6 takes with 2 interrupts, saw %0d with %0d",
                   take_count, irq_take_count);
        end
    end

endmodule

/* rtl/cp0_pkg.sv */
package cp0_pkg;

    // data and address words, pc and cp0 register contents
    typedef logic [31:0] word_t;

    // cause ExcCode field
    // 0 is an interrupt in cause, "nothing pending" from the pipeline
    typedef logic [4:0] exc_code_t;

    // one bit per external interrupt line, also used for the IM mask
    typedef logic [5:0] irq_t;

    // cp0 register numbers as carried in the rd field
    typedef enum logic [4:0] {
        CP0_STATUS = 5'd12,
        CP0_CAUSE  = 5'd13,
        CP0_EPC    = 5'd14,
        CP0_PRID   = 5'd15
    } cp0_reg_e;

endpackage

/* rtl/cp0_regs.sv */
`timescale 1ns/1ps
`include "cp0_settings.svh"

module cp0_regs (
    input  logic                clk,
    input  logic                reset,
    input  cp0_pkg::word_t      instr,          // instruction in execute
    input  cp0_pkg::word_t      pc,
    input  logic                in_delay_slot,
    input  cp0_pkg::word_t      write_data,     // rt value for mtc0
    input  cp0_pkg::irq_t       irq_pending,
    input  logic                take,
    input  cp0_pkg::exc_code_t  take_code,
    output cp0_pkg::irq_t       status_im,
    output logic                status_ie,
    output logic                status_exl,
    output cp0_pkg::word_t      epc_out,
    output cp0_pkg::word_t      read_data
);

    import cp0_pkg::*;

    word_t      status_q;
    word_t      cause_q;
    word_t      epc_q;

    logic [4:0] rd;
    logic       is_eret;
    logic       is_mtc0;
    word_t      epc_next;

    assign rd      = instr[15:11];
    assign is_eret = (instr == `CP0_ERET_WORD);
    assign is_mtc0 = (instr[31:21] == `CP0_MTC0_PREFIX);

    // branch address when the faulting instruction sits in a delay slot
    assign epc_next = in_delay_slot ? pc - 32'd4 : pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            status_q <= '0;
            cause_q  <= '0;
            epc_q    <= '0;
        end else begin
            if (take) begin
                // capture beats eret and mtc0 in the same cycle
                epc_q         <= epc_next;
                cause_q[31]   <= in_delay_slot;  // BD
                cause_q[6:2]  <= take_code;      // ExcCode
                status_q[1]   <= 1'b1;           // EXL
            end else if (is_eret) begin
                status_q[1] <= 1'b0;
            end else if (is_mtc0) begin
                case (rd)
                    CP0_STATUS: status_q <= write_data;
                    CP0_CAUSE:  cause_q  <= write_data;
                    CP0_EPC:    epc_q    <= write_data;
                    default: begin
                        // prid is read-only and other numbers are not implemented
                    end
                endcase
            end

            // IP field follows the lines every cycle and overrides any mtc0 above
            cause_q[15:10] <= irq_pending;
        end
    end

    assign status_im  = status_q[15:10];
    assign status_ie  = status_q[0];
    assign status_exl = status_q[1];

    assign epc_out = {epc_q[31:2], 2'b00};  // word aligned return address

    // mfc0 path decoded from rd alone
    always_comb begin
        case (rd)
            CP0_STATUS: read_data = status_q;
            CP0_CAUSE:  read_data = cause_q;
            CP0_EPC:    read_data = epc_q;
            CP0_PRID:   read_data = `CP0_PRID_VALUE;
            default:    read_data = '1;
        endcase
    end

    // the handler always starts with EXL set
    a_take_sets_exl: assert property (
        @(posedge clk) disable iff (reset)
        take |=> status_exl
    ) else $error("EXL not set after take");

    // an mtc0 naming prid writes nothing
    a_prid_read_only: assert property (
        @(posedge clk) disable iff (reset)
        (is_mtc0 && rd == CP0_PRID && !take) |=>
            $stable(status_q) && $stable(epc_q) &&
            $stable(cause_q[31:16]) && $stable(cause_q[9:0])
    ) else $error("mtc0 to prid changed another register");

endmodule

/* rtl/cp0_settings.svh */
`ifndef CP0_SETTINGS_SVH
`define CP0_SETTINGS_SVH

// processor id, reset and read value of register 15
`define CP0_PRID_VALUE      32'h0001_9300

// full eret encoding: cop0, co=1, funct 0x18
`define CP0_ERET_WORD       32'h4200_0018

// instr[31:21] of the move instructions (opcode + rs)
`define CP0_MTC0_PREFIX     11'b010_0000_0100
`define CP0_MFC0_PREFIX     11'b010_0000_0000

// exception codes for the cause ExcCode field
`define EXC_INT             5'd0   // interrupt
`define EXC_ADEL            5'd4   // address error, load or fetch
`define EXC_ADES            5'd5   // address error, store
`define EXC_RI              5'd10  // reserved instruction
`define EXC_OV              5'd12  // arithmetic overflow

`endif

/* rtl/exc_detect.sv */
`timescale 1ns/1ps
`include "cp0_settings.svh"

// decides each cycle whether the pipeline goes to the handler
// interrupts win over synchronous exceptions
module exc_detect (
    input  cp0_pkg::irq_t       irq_pending,
    input  cp0_pkg::irq_t       status_im,
    input  logic                status_ie,
    input  logic                status_exl,
    input  cp0_pkg::exc_code_t  exc_code,
    output logic                take,
    output cp0_pkg::exc_code_t  take_code
);

    import cp0_pkg::*;

    irq_t irq_masked;
    logic irq_req;
    logic exc_supported;
    logic exc_req;

    assign irq_masked = irq_pending & status_im;

    // any unmasked line, global enable on, not already in a handler
    assign irq_req = (|irq_masked) && status_ie && !status_exl;

    // only these codes come from the pipeline, the rest is dropped
    always_comb begin
        case (exc_code)
            `EXC_ADEL: exc_supported = 1'b1;
            `EXC_ADES: exc_supported = 1'b1;
            `EXC_RI:   exc_supported = 1'b1;
            `EXC_OV:   exc_supported = 1'b1;
            default:   exc_supported = 1'b0;  // incl. 0 = nothing pending
        endcase
    end

    // EXL blocks nesting, IE does not matter here
    assign exc_req = exc_supported && !status_exl;

    always_comb begin
        if (irq_req) begin
            take      = 1'b1;
            take_code = `EXC_INT;
        end else if (exc_req) begin
            take      = 1'b1;
            take_code = exc_code;
        end else begin
            take      = 1'b0;
            take_code = `EXC_INT;   // don't care when take is low
        end
    end

endmodule

/* rtl/exc_unit_top.sv */
`timescale 1ns/1ps

module exc_unit_top (
    input  logic                clk,
    input  logic                reset,
    input  cp0_pkg::word_t      instr,
    input  cp0_pkg::word_t      pc,
    input  logic                in_delay_slot,
    input  cp0_pkg::exc_code_t  exc_code,
    input  cp0_pkg::word_t      write_data,
    input  cp0_pkg::irq_t       irq,            // asynchronous
    output logic                exc_taken,      // redirect to handler
    output cp0_pkg::word_t      epc_out,
    output cp0_pkg::word_t      read_data
);

    import cp0_pkg::*;

    irq_t       irq_pending;
    irq_t       status_im;
    logic       status_ie;
    logic       status_exl;
    logic       take;
    exc_code_t  take_code;

    irq_sync u_irq_sync (
        .clk         (clk),
        .reset       (reset),
        .irq         (irq),
        .irq_pending (irq_pending)
    );

    exc_detect u_exc_detect (
        .irq_pending (irq_pending),
        .status_im   (status_im),
        .status_ie   (status_ie),
        .status_exl  (status_exl),
        .exc_code    (exc_code),
        .take        (take),
        .take_code   (take_code)
    );

    cp0_regs u_cp0_regs (
        .clk           (clk),
        .reset         (reset),
        .instr         (instr),
        .pc            (pc),
        .in_delay_slot (in_delay_slot),
        .write_data    (write_data),
        .irq_pending   (irq_pending),
        .take          (take),
        .take_code     (take_code),
        .status_im     (status_im),
        .status_ie     (status_ie),
        .status_exl    (status_exl),
        .epc_out       (epc_out),
        .read_data     (read_data)
    );

    assign exc_taken = take;

    // guards exc_detect, which has no clock of its own
    // no new exception may start while a handler runs
    a_no_take_in_exl: assert property (
        @(posedge clk) disable iff (reset)
        !(take && status_exl)
    ) else $error("take raised with EXL set");

endmodule

/* rtl/irq_sync.sv */
`timescale 1ns/1ps

module irq_sync #(
    parameter int SYNC_STAGES = 2
) (
    input  logic            clk,
    input  logic            reset,
    input  cp0_pkg::irq_t   irq,          // asynchronous lines
    output cp0_pkg::irq_t   irq_pending
);

    import cp0_pkg::*;

    irq_t sync_q [SYNC_STAGES];  // stage 0 may go metastable

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= irq;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // last stage only, settled
    assign irq_pending = sync_q[SYNC_STAGES-1];

endmodule

/* src.f */
+incdir+rtl
rtl/cp0_pkg.sv
rtl/irq_sync.sv
rtl/exc_detect.sv
rtl/cp0_regs.sv
rtl/exc_unit_top.sv
bench/exc_unit_tb.sv
